// File: dmacRegs.f
dmacPkg.sv
regBusControl.sv
flashRegisters.sv
flashArray.sv
dmaSetupRegs.sv
regTop.sv
regBus_properties.sv
tbClock.sv
regTb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run regTb and check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --assert --timing -Wno-fatal --top-module regTb -f dmacRegs.f -o simv
	./obj_dir/simv +verilator+error+limit+100 | tee $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: regTb.sv
// testbench top for regTop, runs random bus cycles over every region while bound assertions check

`timescale 1ns/1ps

module regTb;

	localparam int          NUM_CYCLES  = 200;
	localparam int          CLK_PERIOD  = 100;
	localparam int          WATCHDOG_NS = NUM_CYCLES * 20 * CLK_PERIOD;
	localparam logic [31:0] SEED        = 32'hd74deb5b;

	logic                       CLK;
	logic                       nRST;
	dmacPkg::busReqT            req;
	logic                       term;
	logic [dmacPkg::DATA_W-1:0] rdata;
	dmacPkg::dmaCfgT            dmaCfg;
	logic [31:0]                rngState;
	int                         cycleCount;

	tbClock clkGen (.CLK(CLK), .nRST(nRST));

	regTop dut (
		.CLK    (CLK),
		.nRST   (nRST),
		.req    (req),
		.term   (term),
		.rdata  (rdata),
		.dmaCfg (dmaCfg)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic nextRand(output logic [31:0] r);
		rngState = xorshift(rngState);
		r = rngState;
	endtask

	function automatic logic [23:0] flashAddr(input logic [31:0] r);
		return {5'b0, r[18:2], 2'b00};
	endfunction

	// same array word seen through other window bits
	function automatic logic [23:0] aliasAddr(input logic [23:0] a, input logic [31:0] r);
		return {5'b0, r[18:10], a[9:2], 2'b00};
	endfunction

	function automatic logic [23:0] dmaAddr(input logic [1:0] off);
		return {dmacPkg::DMA_BASE[23:4], off, 2'b00};
	endfunction

	function automatic logic [23:0] unmappedAddr(input logic [31:0] r);
		if (r[31])
			return {r[23:20] | 4'h2, r[19:2], 2'b00}; // above the DMA block
		return dmacPkg::FLASH_CTRL_ADDR | {5'b0, r[18:2] | 17'd1, 2'b00};
	endfunction

	// ========================================================================
	// bus cycles, each starts and ends on a rising edge
	// ========================================================================

	task automatic runCycle(input logic [23:0] addr, input logic [31:0] wdata, input logic isWrite);
		req.addr  <= addr;
		req.wdata <= wdata;
		req.rd    <= !isWrite;
		req.wr    <= isWrite;
		@(posedge CLK);
		while (term !== 1'b1)
			@(posedge CLK);
		req.rd <= 1'b0;
		req.wr <= 1'b0;
		@(posedge CLK); // idle clock
		cycleCount++;
	endtask

	task automatic writeBus(input logic [23:0] addr, input logic [31:0] wdata);
		runCycle(addr, wdata, 1'b1);
	endtask

	task automatic readBus(input logic [23:0] addr);
		runCycle(addr, rngState, 1'b0);
	endtask

	task automatic writeReadFlash(input logic [23:0] addr, input logic [31:0] wdata);
		logic [31:0] r;
		writeBus(addr, wdata);
		nextRand(r);
		readBus(aliasAddr(addr, r));
	endtask

	task automatic flashBurst(input int n);
		logic [31:0] a;
		logic [31:0] d;
		repeat (n) begin
			nextRand(a);
			nextRand(d);
			writeReadFlash(flashAddr(a), d);
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before all bus cycles finished");
		$display("Verification failed");
		$fatal(1, "simulation timed out");
	end

	// stop at the first assertion failure
	always @(negedge CLK) begin
		if (dut.props.errCount != 0) begin
			$display("Verification failed");
			$fatal(1, "a bus assertion failed");
		end
	end

	initial begin
		logic [31:0] k;
		logic [31:0] a;
		logic [31:0] d;
		req        = '0;
		rngState   = SEED;
		cycleCount = 0;
		wait (nRST === 1'b1);
		@(posedge CLK);

		for (int i = 0; i < 4; i++)
			readBus(dmaAddr(i[1:0]));               // reset values and status
		readBus(dmacPkg::FLASH_CTRL_ADDR);
		flashBurst(4);                              // writes enable still clear
		writeBus(dmacPkg::FLASH_CTRL_ADDR, 32'h1);
		readBus(dmacPkg::FLASH_CTRL_ADDR);
		flashBurst(4);
		writeBus(dmaAddr(2'd1), 32'h0);
		readBus(dmaAddr(2'd3));
		writeBus(dmaAddr(2'd1), 32'h40);
		readBus(dmaAddr(2'd3));
		writeBus(dmaAddr(2'd3), 32'hffffffff);      // status is read only
		readBus(dmaAddr(2'd3));

		while (cycleCount < NUM_CYCLES) begin
			nextRand(k);
			nextRand(a);
			nextRand(d);
			case (k[2:0])
				3'd0:    readBus(flashAddr(a));
				3'd1:    writeReadFlash(flashAddr(a), d);
				3'd2:    writeBus(dmacPkg::FLASH_CTRL_ADDR, d); // random enable bit
				3'd3:    readBus(dmacPkg::FLASH_CTRL_ADDR);
				3'd4:    writeBus(dmaAddr(a[1:0]), d);
				3'd5:    readBus(dmaAddr(a[1:0]));
				3'd6:    readBus(unmappedAddr(a));
				default: writeBus(unmappedAddr(a), d);
			endcase
		end

		repeat (2) @(posedge CLK);
		if (dut.props.errCount == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("Verification failed");
			$fatal(1, "assertion errors were reported");
		end
	end

endmodule

// File: tbClock.sv
// testbench clock and reset source, 100 ns clock with reset held low for the first 16 cycles

`timescale 1ns/1ps

module tbClock (
	output logic CLK,
	output logic nRST
);

	localparam int HALF_PERIOD  = 50;
	localparam int RESET_CYCLES = 16;

	initial begin
		CLK = 1'b0;
		forever #HALF_PERIOD CLK = ~CLK;
	end

	initial begin
		nRST = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		nRST <= 1'b1; // released on a rising edge
	end

endmodule

// File: regBus_properties.sv
// bus checker bound into regTop, keeps shadow registers and checks term timing and read data

`timescale 1ns/1ps

module regBusProperties (
	input logic                       CLK,
	input logic                       nRST,
	input dmacPkg::busReqT            req,
	input logic                       term,
	input logic [dmacPkg::DATA_W-1:0] rdata,
	input dmacPkg::dmaCfgT            dmaCfg
);

	typedef enum logic [1:0] {rgnNone, rgnFlash, rgnCtrl, rgnDma} rgnT;

	logic [dmacPkg::DATA_W-1:0]     shadowFlash [dmacPkg::FLASH_WORDS];
	logic [dmacPkg::DATA_W-1:0]     shadowCtrl;
	dmacPkg::dmaCfgT                shadowCfg;
	logic [dmacPkg::DATA_W-1:0]     expRdata;
	logic [dmacPkg::WAIT_CNT_W-1:0] cycLen;   // clocks since strobe rise
	logic                           termPrev;
	logic                           strobe;
	rgnT                            rgn;
	int                             errCount = 0;

	function automatic rgnT regionOf(input logic [dmacPkg::ADDR_W-1:0] a);
		if (a == dmacPkg::FLASH_CTRL_ADDR)
			return rgnCtrl;
		if (a < dmacPkg::FLASH_CTRL_ADDR)
			return rgnFlash; // window ends right below the control register
		if (a[dmacPkg::ADDR_W-1:4] == dmacPkg::DMA_BASE[dmacPkg::ADDR_W-1:4])
			return rgnDma;
		return rgnNone;
	endfunction

	assign strobe = req.rd | req.wr;
	assign rgn    = regionOf(req.addr);

	always_comb begin
		case (rgn)
			rgnFlash: expRdata = shadowFlash[req.addr[dmacPkg::FLASH_IDX_W+1:2]];
			rgnCtrl:  expRdata = shadowCtrl;
			rgnDma: begin
				case (req.addr[3:2])
					2'd0:    expRdata = shadowCfg.address;
					2'd1:    expRdata = shadowCfg.count;
					2'd2:    expRdata = shadowCfg.control;
					default: expRdata = 32'(shadowCfg.count == '0); // status
				endcase
			end
			default:  expRdata = '0;
		endcase
	end

	// ========================================================================
	// shadow state, updated when a write completes
	// ========================================================================

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < dmacPkg::FLASH_WORDS; i++)
				shadowFlash[i] <= '0;
			shadowCtrl <= '0;
			shadowCfg  <= '0;
			cycLen     <= '0;
			termPrev   <= 1'b0;
		end else begin
			termPrev <= term;
			if (!strobe)
				cycLen <= '0;
			else if (cycLen != '1)
				cycLen <= cycLen + 1'b1;

			if (term && !termPrev && req.wr) begin
				case (rgn)
					rgnFlash: begin
						if (shadowCtrl[0]) // disabled writes leave the word alone
							shadowFlash[req.addr[dmacPkg::FLASH_IDX_W+1:2]] <= req.wdata;
					end
					rgnCtrl: shadowCtrl <= req.wdata;
					rgnDma: begin
						case (req.addr[3:2])
							2'd0:    shadowCfg.address <= req.wdata;
							2'd1:    shadowCfg.count   <= req.wdata;
							2'd2:    shadowCfg.control <= req.wdata;
							default: ;
						endcase
					end
					default: ;
				endcase
			end
		end
	end

	// ========================================================================
	// checks
	// ========================================================================

	resetValues: assert property (@(posedge CLK) $rose(nRST) |-> !term && dmaCfg == '0)
		else begin
			errCount++;
			$error("FAIL term %h dmaCfg %h after reset, expected 0", $sampled(term),
				$sampled(dmaCfg));
		end

	termNeedsStrobe: assert property (@(posedge CLK) disable iff (!nRST)
		term |-> strobe || $past(strobe))
		else begin
			errCount++;
			$error("term was high with no strobe on the bus");
		end

	termFalls: assert property (@(posedge CLK) disable iff (!nRST) $fell(strobe) |=> !term)
		else begin
			errCount++;
			$error("term did not fall the clock after the strobe dropped");
		end

	regTiming: assert property (@(posedge CLK) disable iff (!nRST)
		$rose(term) && rgn != rgnFlash |-> cycLen == dmacPkg::REG_WAIT + 4'd1)
		else begin
			errCount++;
			$error("FAIL term after %h clocks at addr %h, expected %h", $sampled(cycLen),
				$sampled(req.addr), dmacPkg::REG_WAIT + 4'd1);
		end

	readData: assert property (@(posedge CLK) disable iff (!nRST)
		$rose(term) && req.rd |-> rdata == expRdata)
		else begin
			errCount++;
			$error("FAIL rdata %h at addr %h, expected %h", $sampled(rdata),
				$sampled(req.addr), $sampled(expRdata));
		end

	// between cycles the outputs must match what was written
	cfgShadow: assert property (@(posedge CLK) disable iff (!nRST)
		!strobe |-> dmaCfg == shadowCfg)
		else begin
			errCount++;
			$error("FAIL dmaCfg %h, expected %h", $sampled(dmaCfg), $sampled(shadowCfg));
		end

endmodule

bind regTop regBusProperties props (
	.CLK    (CLK),
	.nRST   (nRST),
	.req    (req),
	.term   (term),
	.rdata  (rdata),
	.dmaCfg (dmaCfg)
);

// File: regTop.sv
// top of the register subsystem, connects the bus control to the flash and DMA blocks

`timescale 1ns/1ps

module regTop (
	input  logic                       CLK,
	input  logic                       nRST,
	input  dmacPkg::busReqT            req,
	output logic                       term,
	output logic [dmacPkg::DATA_W-1:0] rdata,
	output dmacPkg::dmaCfgT            dmaCfg
);

	dmacPkg::tgtReqT   flashReq;
	dmacPkg::tgtRspT   flashRsp;
	dmacPkg::tgtReqT   dmaReq;
	dmacPkg::tgtRspT   dmaRsp;
	dmacPkg::flashCmdT flashCmd;
	dmacPkg::flashRspT flashArrRsp; // array side of the flash block

	regBusControl busCtrl (
		.CLK      (CLK),
		.nRST     (nRST),
		.req      (req),
		.flashReq (flashReq),
		.flashRsp (flashRsp),
		.dmaReq   (dmaReq),
		.dmaRsp   (dmaRsp),
		.term     (term),
		.rdata    (rdata)
	);

	flashRegisters flashRegs (
		.CLK      (CLK),
		.nRST     (nRST),
		.req      (flashReq),
		.rsp      (flashRsp),
		.cmd      (flashCmd),
		.flashRsp (flashArrRsp)
	);

	flashArray flashMem (
		.CLK  (CLK),
		.nRST (nRST),
		.cmd  (flashCmd),
		.rsp  (flashArrRsp)
	);

	dmaSetupRegs dmaRegs (
		.CLK  (CLK),
		.nRST (nRST),
		.req  (dmaReq),
		.rsp  (dmaRsp),
		.cfg  (dmaCfg)
	);

endmodule

// File: dmaSetupRegs.sv
// DMA address, count and control registers with a read-only status word

`timescale 1ns/1ps

module dmaSetupRegs (
	input  logic            CLK,
	input  logic            nRST,
	input  dmacPkg::tgtReqT req,
	output dmacPkg::tgtRspT rsp,
	output dmacPkg::dmaCfgT cfg
);

	logic                              strobe;
	logic [dmacPkg::WAIT_CNT_W-1:0]    cnt;
	logic [dmacPkg::DATA_W-1:0]        addrReg;
	logic [dmacPkg::DATA_W-1:0]        countReg;
	logic [dmacPkg::DATA_W-1:0]        ctrlReg;
	logic                              countZero;

	assign strobe    = req.rd | req.wr;
	assign countZero = (countReg == '0);

	// ========================================================================
	// register writes, taken on the first clock of the cycle
	// ========================================================================

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			cnt      <= '0;
			addrReg  <= '0;
			countReg <= '0;
			ctrlReg  <= '0;
		end else begin
			if (!strobe)
				cnt <= '0;
			else if (cnt != dmacPkg::REG_WAIT)
				cnt <= cnt + 1'b1;

			if (req.wr && (cnt == '0)) begin
				case (req.addr[3:2])
					2'd0:    addrReg  <= req.wdata;
					2'd1:    countReg <= req.wdata;
					2'd2:    ctrlReg  <= req.wdata;
					default: ; // status word ignores writes
				endcase
			end
		end
	end

	always_comb begin
		case (req.addr[3:2])
			2'd0:    rsp.rdata = addrReg;
			2'd1:    rsp.rdata = countReg;
			2'd2:    rsp.rdata = ctrlReg;
			default: rsp.rdata = {{(dmacPkg::DATA_W-1){1'b0}}, countZero};
		endcase
		rsp.done = strobe && (cnt == dmacPkg::REG_WAIT);
	end

	always_comb begin
		cfg.address = addrReg;
		cfg.count   = countReg;
		cfg.control = ctrlReg;
	end

endmodule

// File: flashArray.sv
// word array model of the flash interface, acknowledges each command after a fixed latency

`timescale 1ns/1ps

module flashArray (
	input  logic              CLK,
	input  logic              nRST,
	input  dmacPkg::flashCmdT cmd,
	output dmacPkg::flashRspT rsp
);

	logic [dmacPkg::DATA_W-1:0]        mem [dmacPkg::FLASH_WORDS];
	logic                              busy;
	logic [dmacPkg::WAIT_CNT_W-1:0]    lat;
	logic [dmacPkg::FLASH_IDX_W-1:0]   idx;  // word to return on ack

	// ========================================================================
	// storage and acknowledge timing
	// ========================================================================

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < dmacPkg::FLASH_WORDS; i++)
				mem[i] <= '0;
			busy <= 1'b0;
			lat  <= '0;
			idx  <= '0;
			rsp  <= '0;
		end else begin
			rsp.ack <= 1'b0; // ack is a one clock pulse

			if (cmd.write)
				mem[cmd.index] <= cmd.wdata;

			if (cmd.read || cmd.write) begin
				busy <= 1'b1;
				lat  <= 4'd1;
				idx  <= cmd.index;
			end else if (busy) begin
				if (lat == dmacPkg::FLASH_ACK_LAT) begin
					busy      <= 1'b0;
					rsp.ack   <= 1'b1;
					rsp.rdata <= mem[idx];
				end else begin
					lat <= lat + 1'b1;
				end
			end
		end
	end

endmodule

// File: flashRegisters.sv
// flash window and flash control register that turn bus cycles into single flash commands

`timescale 1ns/1ps

module flashRegisters (
	input  logic              CLK,
	input  logic              nRST,
	input  dmacPkg::tgtReqT   req,
	output dmacPkg::tgtRspT   rsp,
	output dmacPkg::flashCmdT cmd,
	input  dmacPkg::flashRspT flashRsp
);

	logic                              strobe;
	logic                              isCtrl;
	logic                              wrEn;
	logic [dmacPkg::WAIT_CNT_W-1:0]    cnt;      // clocks since strobe rise
	logic                              doneReg;
	logic [dmacPkg::DATA_W-1:0]        ctrlReg;
	logic [dmacPkg::DATA_W-1:0]        readData;

	assign strobe = req.rd | req.wr;
	assign isCtrl = (req.addr == dmacPkg::FLASH_CTRL_ADDR);
	assign wrEn   = ctrlReg[0];

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST)
			cnt <= '0;
		else if (!strobe)
			cnt <= '0;
		else if (cnt != '1)
			cnt <= cnt + 1'b1; // saturates on long stretched cycles
	end

	// ========================================================================
	// commands toward the flash array
	// ========================================================================

	always_comb begin
		cmd.index = req.addr[dmacPkg::FLASH_IDX_W+1:2]; // window aliases onto the array
		cmd.wdata = req.wdata;
		cmd.read  = req.rd && !isCtrl && (cnt == '0);
		// write only goes out after the strobe has settled
		cmd.write = req.wr && !isCtrl && wrEn && (cnt == dmacPkg::WRITE_SETTLE);
	end

	// ========================================================================
	// control register and completion
	// ========================================================================

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			ctrlReg <= '0;
			doneReg <= 1'b0;
		end else begin
			if (req.wr && isCtrl && (cnt == '0))
				ctrlReg <= req.wdata;

			if (!strobe)
				doneReg <= 1'b0;
			else if (flashRsp.ack)
				doneReg <= 1'b1;
			else if (req.wr && !isCtrl && !wrEn &&
					(cnt == dmacPkg::WRITE_SETTLE + dmacPkg::FLASH_ACK_LAT + 1'b1))
				doneReg <= 1'b1; // disabled write finishes as if the array had acked
		end
	end

	// read data is captured on the ack
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST)
			readData <= '0;
		else if (flashRsp.ack && req.rd)
			readData <= flashRsp.rdata;
	end

	always_comb begin
		rsp.rdata = isCtrl ? ctrlReg : readData;
		rsp.done  = strobe && (doneReg || (isCtrl && cnt >= dmacPkg::REG_WAIT));
	end

endmodule

// File: regBusControl.sv
// host side of the register bus, decodes each cycle to one target and returns term and read data

`timescale 1ns/1ps

module regBusControl (
	input  logic                           CLK,
	input  logic                           nRST,
	input  dmacPkg::busReqT                req,
	output dmacPkg::tgtReqT                flashReq,
	input  dmacPkg::tgtRspT                flashRsp,
	output dmacPkg::tgtReqT                dmaReq,
	input  dmacPkg::tgtRspT                dmaRsp,
	output logic                           term,
	output logic [dmacPkg::DATA_W-1:0]     rdata
);

	typedef enum logic [1:0] {
		selNone,
		selFlash,
		selDma
	} selT;

	logic                              strobe;
	logic                              active;   // strobe was high last clock
	selT                               selNow;
	selT                               selReg;
	selT                               sel;
	logic [dmacPkg::WAIT_CNT_W-1:0]    waitCnt;
	logic                              noneDone;
	logic                              selDone;
	logic [dmacPkg::DATA_W-1:0]        selRdata;

	assign strobe = req.rd | req.wr;

	// ========================================================================
	// address decode
	// ========================================================================

	always_comb begin
		if (req.addr[dmacPkg::ADDR_W-1:dmacPkg::FLASH_WIN_LSB] ==
				dmacPkg::FLASH_BASE[dmacPkg::ADDR_W-1:dmacPkg::FLASH_WIN_LSB])
			selNow = selFlash;
		else if (req.addr == dmacPkg::FLASH_CTRL_ADDR)
			selNow = selFlash; // control register lives in the flash block
		else if (req.addr[dmacPkg::ADDR_W-1:dmacPkg::DMA_WIN_LSB] ==
				dmacPkg::DMA_BASE[dmacPkg::ADDR_W-1:dmacPkg::DMA_WIN_LSB])
			selNow = selDma;
		else
			selNow = selNone;
	end

	// decode on the first clock, then hold until the strobe drops
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			active <= 1'b0;
			selReg <= selNone;
		end else begin
			active <= strobe;
			if (strobe && !active)
				selReg <= selNow;
		end
	end

	assign sel = active ? selReg : selNow;

	always_comb begin
		flashReq.addr  = req.addr;
		flashReq.wdata = req.wdata;
		flashReq.rd    = req.rd && (sel == selFlash);
		flashReq.wr    = req.wr && (sel == selFlash);
		dmaReq.addr    = req.addr;
		dmaReq.wdata   = req.wdata;
		dmaReq.rd      = req.rd && (sel == selDma);
		dmaReq.wr      = req.wr && (sel == selDma);
	end

	// unmapped cycles just wait out REG_WAIT
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST)
			waitCnt <= '0;
		else if (!strobe || sel != selNone)
			waitCnt <= '0;
		else if (!noneDone)
			waitCnt <= waitCnt + 1'b1;
	end

	assign noneDone = (waitCnt == dmacPkg::REG_WAIT);

	always_comb begin
		case (sel)
			selFlash: begin
				selDone  = flashRsp.done;
				selRdata = flashRsp.rdata;
			end
			selDma: begin
				selDone  = dmaRsp.done;
				selRdata = dmaRsp.rdata;
			end
			default: begin
				selDone  = noneDone;
				selRdata = '0; // unmapped reads return zero
			end
		endcase
	end

	// term follows done by one clock and drops the clock after the strobe
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			term  <= 1'b0;
			rdata <= '0;
		end else begin
			term <= strobe && selDone;
			if (strobe && selDone && !term)
				rdata <= selRdata;   // held for as long as term stays up
		end
	end

endmodule

// File: dmacPkg.sv
// address map, timing constants and bus types shared by every register block file

package dmacPkg;

	// ========================================================================
	// bus widths and flash model size
	// ========================================================================

	localparam int ADDR_W = 24;
	localparam int DATA_W = 32;

	localparam int FLASH_WORDS = 256;
	localparam int FLASH_IDX_W = $clog2(FLASH_WORDS);

	// ========================================================================
	// address map
	// ========================================================================

	localparam logic [ADDR_W-1:0] FLASH_BASE      = 24'h000000; // window up to 0x07FFFF
	localparam logic [ADDR_W-1:0] FLASH_CTRL_ADDR = 24'h080000;
	localparam logic [ADDR_W-1:0] DMA_BASE        = 24'h100000; // four words

	localparam int FLASH_WIN_LSB = 19; // window spans 512 KB
	localparam int DMA_WIN_LSB   = 4;

	// ========================================================================
	// cycle timing, all counted in clocks
	// ========================================================================

	localparam int WAIT_CNT_W = 4;

	localparam logic [WAIT_CNT_W-1:0] WRITE_SETTLE  = 4'd3;
	localparam logic [WAIT_CNT_W-1:0] FLASH_ACK_LAT = 4'd2;
	localparam logic [WAIT_CNT_W-1:0] REG_WAIT      = 4'd2;

	// ========================================================================
	// bus structs
	// ========================================================================

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic              rd;
		logic              wr;
	} busReqT;

	// same fields as the host request, strobes only reach the selected target
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic              rd;
		logic              wr;
	} tgtReqT;

	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic              done;
	} tgtRspT;

	typedef struct packed {
		logic [FLASH_IDX_W-1:0] index;
		logic [DATA_W-1:0]      wdata;
		logic                   read;
		logic                   write;
	} flashCmdT;

	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic              ack;
	} flashRspT;

	typedef struct packed {
		logic [DATA_W-1:0] address;
		logic [DATA_W-1:0] count;
		logic [DATA_W-1:0] control;
	} dmaCfgT;

endpackage
